// ==== bench/fabric_tb.sv ====
// fixed 3x3 grid only; tile index is (row-1)*3+(col-1), stimulus table holds at most 160 entries
`timescale 1ns/100ps
`include "fabric_defs.svh"

module fabric_tb
import mesh_pkg::*;
import trans_pkg::*;
;

localparam int NT      = 9;
localparam int MAX_ENT = 160;

logic                 clk;
logic                 arst_n;
logic [NT-1:0]        inj_valid, inj_ready, ej_valid, ej_ready;
t_tile_trans [NT-1:0] inj_trans, ej_trans;
logic [NT-1:0]        inj_fire, held_valid;
t_tile_trans [NT-1:0] held;
// expected packets per source and destination pair, in table order
t_tile_trans          exp_q [NT][NT][$];
int                   tab_src [MAX_ENT];
int                   tab_dst [MAX_ENT];
logic [`DATA_W-1:0]   tab_data [MAX_ENT];
int                   n_ent, n_loop, n_route, n_conc, err_count, outstanding, delivered;
int                   tests_run, tests_failed, cycles, limit;
logic [31:0]          lfsr = 32'h9ec5;

fabric fabric_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .inj_valid (inj_valid),
    .inj_trans (inj_trans),
    .inj_ready (inj_ready),
    .ej_valid  (ej_valid),
    .ej_trans  (ej_trans),
    .ej_ready  (ej_ready)
);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

// x^32 + x^22 + x^2 + x + 1
function automatic logic next_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
endfunction

function automatic t_tile_id tile_id(input int idx);
    t_tile_id id;
    id.col = `COORD_W'(idx % 3 + 1);
    id.row = `COORD_W'(idx / 3 + 1);
    return id;
endfunction

function automatic int tile_index(input t_tile_id id);
    if (id.col < 1 || id.col > 3 || id.row < 1 || id.row > 3) begin
        return -1;
    end
    return (int'(id.row) - 1) * 3 + int'(id.col) - 1;
endfunction

function automatic t_tile_trans table_pkt(input int e);
    t_tile_trans p;
    p.src  = tile_id(tab_src[e]);
    p.dst  = tile_id(tab_dst[e]);
    p.data = tab_data[e];
    return p;
endfunction

task automatic add_entry(input int s, input int d, input logic [`DATA_W-1:0] data);
    tab_src[n_ent]  = s;
    tab_dst[n_ent]  = d;
    tab_data[n_ent] = data;
    n_ent++;
endtask

// samples at the rising edge, before any register in the fabric moves
always @(posedge clk) begin : monitor
    t_tile_trans want;
    int s;
    inj_fire <= inj_valid & inj_ready;
    for (int t = 0; t < NT; t++) begin
        if (held_valid[t] && (!ej_valid[t] || ej_trans[t] != held[t])) begin
            $display("Mismatch ej_trans[%0d] under stall: held %h, now %h valid %h",
                     t, held[t], ej_trans[t], ej_valid[t]);
            err_count++;
        end
        if (ej_valid[t] && ej_ready[t]) begin
            s = tile_index(ej_trans[t].src);
            if (s < 0 || exp_q[s][t].size() == 0) begin
                $display("tile %0d delivered packet %h that nobody sent to it", t, ej_trans[t]);
                err_count++;
            end else begin
                want = exp_q[s][t].pop_front();
                if (ej_trans[t] != want) begin
                    $display("Mismatch ej_trans[%0d]: expected %h, got %h", t, want, ej_trans[t]);
                    err_count++;
                end
                outstanding--;
                delivered++;
            end
        end
    end
    held_valid <= ej_valid & ~ej_ready;
    held       <= ej_trans;
end

always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
        $display("timeout after %0d cycles, %0d packets never delivered",
                 cycles, n_ent - delivered);
        $display("Finished with errors");
        $finish;
    end
end

// mode 0 free flow, 1 random gaps and ej_ready, 2 tile 4 stalled for 80 cycles
task automatic run_test(input string name, input int first, input int last, input int mode);
    int   cur [NT];
    int   errs_before;
    int   cyc;
    logic busy;
    logic blocked;
    logic go;
    errs_before = err_count;
    cyc         = 0;
    blocked     = 1'b0;
    for (int t = 0; t < NT; t++) begin
        cur[t] = first;
    end
    do begin
        @(negedge clk);
        cyc++;
        busy = 1'b0;
        for (int t = 0; t < NT; t++) begin
            if (inj_valid[t] && inj_fire[t]) begin
                inj_valid[t] = 1'b0;
                cur[t]++;
            end
            while (cur[t] < last && tab_src[cur[t]] != t) begin
                cur[t]++;
            end
            go = (mode == 1) ? next_bit() : 1'b1;
            if (!inj_valid[t] && cur[t] < last && go) begin
                inj_trans[t] = table_pkt(cur[t]);
                inj_valid[t] = 1'b1;
                exp_q[t][tab_dst[cur[t]]].push_back(table_pkt(cur[t]));
                outstanding++;
            end
            busy    |= cur[t] < last;
            blocked |= inj_valid[t] && !inj_ready[t];
            ej_ready[t] = (mode == 1) ? next_bit() : !(mode == 2 && t == 4 && cyc < 80);
        end
    end while (busy || outstanding != 0);
    if (mode == 2 && !blocked) begin
        $display("inj_ready never dropped while the destination was stalled");
        err_count++;
    end
    tests_run++;
    if (err_count != errs_before) begin
        tests_failed++;
    end
    $display("test %-14s %s, %0d errors", name,
             (err_count == errs_before) ? "passed" : "FAILED", err_count - errs_before);
endtask

initial begin
    inj_valid = '0;
    inj_trans = '0;
    ej_ready  = '1;
    arst_n    = 1'b0;
    for (int t = 0; t < NT; t++) begin
        add_entry(t, t, 16'h1000 + 16'(t));
    end
    n_loop = n_ent;
    // corners both ways, then the four neighbours of the centre and back
    add_entry(0, 8, 16'h2008);
    add_entry(8, 0, 16'h2080);
    add_entry(2, 6, 16'h2026);
    add_entry(6, 2, 16'h2062);
    add_entry(4, 1, 16'h2041);
    add_entry(4, 3, 16'h2043);
    add_entry(4, 5, 16'h2045);
    add_entry(4, 7, 16'h2047);
    add_entry(1, 4, 16'h2014);
    add_entry(7, 4, 16'h2074);
    n_route = n_ent;
    // rounds 0 and 2 repeat the same pairs, so order per pair gets tested
    for (int r = 0; r < 3; r++) begin
        for (int t = 0; t < NT; t++) begin
            for (int k = 1; k < NT; k += 3) begin
                add_entry(t, (t + k + int'(r == 1)) % NT, 16'hc000 | 16'(n_ent));
            end
        end
    end
    n_conc = n_ent;
    for (int i = 0; i < 12; i++) begin
        add_entry(3, 4, 16'h5300 + 16'(i));
        add_entry(5, 4, 16'h5500 + 16'(i));
    end
    limit = 200 * n_ent + 100;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    if (ej_valid != '0) begin
        $display("Mismatch ej_valid after reset: expected %h, got %h", {NT{1'b0}}, ej_valid);
        err_count++;
    end
    if (inj_ready != '1) begin
        $display("Mismatch inj_ready after reset: expected %h, got %h", {NT{1'b1}}, inj_ready);
        err_count++;
    end
    tests_run++;
    tests_failed += int'(err_count != 0);
    $display("test %-14s %s, %0d errors", "reset",
             (err_count == 0) ? "passed" : "FAILED", err_count);
    run_test("loopback", 0, n_loop, 0);
    run_test("routes", n_loop, n_route, 0);
    run_test("concurrent", n_route, n_conc, 1);
    run_test("saturation", n_conc, n_ent, 2);
    $display("tests run %0d, failed %0d, errors %0d, packets delivered %0d of %0d",
             tests_run, tests_failed, err_count, delivered, n_ent);
    if (err_count == 0) begin
        $display("Finished with no errors");
    end else begin
        $display("Finished with errors");
    end
    $finish;
end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/mesh_pkg.sv
verilog/trans_pkg.sv
verilog/port_fifo.sv
verilog/route_decode.sv
verilog/switch_arbiter.sv
verilog/mesh_router.sv
verilog/fabric.sv
bench/fabric_tb.sv

// ==== verilog/fabric.sv ====
// fixed 3x3 grid; tile (c,r) sits at flat index (r-1)*3+(c-1) of the inj/ej ports
`timescale 1ns/100ps
`include "fabric_defs.svh"

module fabric
import mesh_pkg::*;
import trans_pkg::*;
#(
    localparam int NUM_TILES = `FABRIC_COLS * `FABRIC_ROWS
)
(
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [NUM_TILES-1:0]        inj_valid,
    input  t_tile_trans [NUM_TILES-1:0] inj_trans,
    output logic [NUM_TILES-1:0]        inj_ready,
    output logic [NUM_TILES-1:0]        ej_valid,
    output t_tile_trans [NUM_TILES-1:0] ej_trans,
    input  logic [NUM_TILES-1:0]        ej_ready
);

localparam int LAST_COL = `FABRIC_COLS + 1;
localparam int LAST_ROW = `FABRIC_ROWS + 1;

// router side of every link, [col][row], edge slots included
logic        [LAST_COL:0][LAST_ROW:0] out_north_valid, out_east_valid;
logic        [LAST_COL:0][LAST_ROW:0] out_south_valid, out_west_valid;
t_tile_trans [LAST_COL:0][LAST_ROW:0] out_north_trans, out_east_trans;
t_tile_trans [LAST_COL:0][LAST_ROW:0] out_south_trans, out_west_trans;
logic        [LAST_COL:0][LAST_ROW:0] in_north_ready, in_east_ready;
logic        [LAST_COL:0][LAST_ROW:0] in_south_ready, in_west_ready;

for (genvar C = 0; C <= LAST_COL; C++) begin : g_edge_col
    for (genvar R = 0; R <= LAST_ROW; R++) begin : g_edge_row
        if (C == 0 || C == LAST_COL || R == 0 || R == LAST_ROW) begin : g_tie
            // nothing arrives from off-grid, and off-grid never stalls
            assign out_north_valid[C][R] = 1'b0;
            assign out_east_valid[C][R]  = 1'b0;
            assign out_south_valid[C][R] = 1'b0;
            assign out_west_valid[C][R]  = 1'b0;
            assign out_north_trans[C][R] = '0;
            assign out_east_trans[C][R]  = '0;
            assign out_south_trans[C][R] = '0;
            assign out_west_trans[C][R]  = '0;
            assign in_north_ready[C][R]  = 1'b1;
            assign in_east_ready[C][R]   = 1'b1;
            assign in_south_ready[C][R]  = 1'b1;
            assign in_west_ready[C][R]   = 1'b1;
        end
    end
end

// port order in the concatenations is LOCAL, WEST, SOUTH, EAST, NORTH
for (genvar C = 1; C <= `FABRIC_COLS; C++) begin : g_tile_col
    for (genvar R = 1; R <= `FABRIC_ROWS; R++) begin : g_tile_row
        localparam int IDX = (R - 1) * `FABRIC_COLS + (C - 1);

        // input from the west comes out of the west tile's east port, and so on
        mesh_router mesh_router_i (
            .clk           (clk),
            .arst_n        (arst_n),
            .local_tile_id (make_tile_id(C, R)),
            .in_valid      ({inj_valid[IDX], out_east_valid[C-1][R], out_north_valid[C][R+1],
                             out_west_valid[C+1][R], out_south_valid[C][R-1]}),
            .in_trans      ({inj_trans[IDX], out_east_trans[C-1][R], out_north_trans[C][R+1],
                             out_west_trans[C+1][R], out_south_trans[C][R-1]}),
            .in_ready      ({inj_ready[IDX], in_west_ready[C][R], in_south_ready[C][R],
                             in_east_ready[C][R], in_north_ready[C][R]}),
            .out_valid     ({ej_valid[IDX], out_west_valid[C][R], out_south_valid[C][R],
                             out_east_valid[C][R], out_north_valid[C][R]}),
            .out_trans     ({ej_trans[IDX], out_west_trans[C][R], out_south_trans[C][R],
                             out_east_trans[C][R], out_north_trans[C][R]}),
            .out_ready     ({ej_ready[IDX], in_east_ready[C-1][R], in_north_ready[C][R+1],
                             in_west_ready[C+1][R], in_south_ready[C][R-1]})
        );
    end
end

endmodule

// ==== verilog/fabric_defs.svh ====
// grid is fixed at 3x3 with 1-based tile numbers; COORD_W must hold FABRIC_COLS+1 and FABRIC_ROWS+1
`ifndef FABRIC_DEFS_SVH
`define FABRIC_DEFS_SVH

// grid size, edge slots sit at index 0 and size+1
`define FABRIC_COLS 3
`define FABRIC_ROWS 3

// input queue entries per router port
`define FIFO_DEPTH 4

// packet field widths
`define COORD_W 4
`define DATA_W 16

`endif

// ==== verilog/mesh_pkg.sv ====
// tile id is column nibble over row nibble; port order here sets the router's port indices
`include "fabric_defs.svh"

package mesh_pkg;

    localparam int NUM_PORTS = 5;

    typedef struct packed {
        logic [`COORD_W-1:0] col;
        logic [`COORD_W-1:0] row;
    } t_tile_id;

    // index into every per-port vector of a router
    typedef enum logic [2:0] {
        NORTH = 3'd0,
        EAST  = 3'd1,
        SOUTH = 3'd2,
        WEST  = 3'd3,
        LOCAL = 3'd4
    } t_port_dir;

    function automatic t_tile_id make_tile_id(input int col, input int row);
        t_tile_id id;
        id.col = col[`COORD_W-1:0];
        id.row = row[`COORD_W-1:0];
        return id;
    endfunction

endpackage

// ==== verilog/mesh_router.sv ====
// one tile's router; every per-port vector is indexed by t_port_dir, LOCAL is the tile port
`timescale 1ns/100ps

module mesh_router
import mesh_pkg::*;
import trans_pkg::*;
(
    input  logic                        clk,
    input  logic                        arst_n,
    input  t_tile_id                    local_tile_id,
    input  logic [NUM_PORTS-1:0]        in_valid,
    input  t_tile_trans [NUM_PORTS-1:0] in_trans,
    output logic [NUM_PORTS-1:0]        in_ready,
    output logic [NUM_PORTS-1:0]        out_valid,
    output t_tile_trans [NUM_PORTS-1:0] out_trans,
    input  logic [NUM_PORTS-1:0]        out_ready
);

logic [NUM_PORTS-1:0]                head_valid;
t_tile_trans [NUM_PORTS-1:0]         head_trans;
logic [NUM_PORTS-1:0]                pop;
// request from each input, one bit per output
logic [NUM_PORTS-1:0][NUM_PORTS-1:0] req;

for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port

    port_fifo port_fifo_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid[p]),
        .in_trans   (in_trans[p]),
        .in_ready   (in_ready[p]),
        .head_valid (head_valid[p]),
        .head_trans (head_trans[p]),
        .pop        (pop[p])
    );

    route_decode route_decode_i (
        .local_tile_id (local_tile_id),
        .head_valid    (head_valid[p]),
        .dst           (head_trans[p].dst),
        .req           (req[p])
    );

end

// allocation and output registers for all five outputs
switch_arbiter switch_arbiter_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .head_trans (head_trans),
    .pop        (pop),
    .out_valid  (out_valid),
    .out_trans  (out_trans),
    .out_ready  (out_ready)
);

endmodule

// ==== verilog/port_fifo.sv ====
// FIFO_DEPTH must be 2 or more; head is read straight from storage, so it is valid a cycle after write
`timescale 1ns/100ps
`include "fabric_defs.svh"

module port_fifo
import trans_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  t_tile_trans in_trans,
    output logic        in_ready,
    output logic        head_valid,
    output t_tile_trans head_trans,
    input  logic        pop
);

localparam int PTR_W = $clog2(`FIFO_DEPTH);

t_tile_trans      mem [`FIFO_DEPTH];
logic [PTR_W-1:0] rd_ptr;
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W:0]   count;
logic             push;

// ready from occupancy only
assign in_ready   = int'(count) < `FIFO_DEPTH;
assign push       = in_valid && in_ready;
assign head_valid = count != '0;
assign head_trans = mem[rd_ptr];

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        rd_ptr <= '0;
        wr_ptr <= '0;
        count  <= '0;
    end else begin
        if (push) begin
            wr_ptr <= (int'(wr_ptr) == `FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= (int'(rd_ptr) == `FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
        end
        count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
end

always_ff @(posedge clk) begin
    if (push) begin
        mem[wr_ptr] <= in_trans;
    end
end

// switch must only pop a queue that shows a head
assert property (@(posedge clk) disable iff (!arst_n) pop |-> head_valid)
    else $error("port_fifo: pop while empty");

endmodule

// ==== verilog/route_decode.sv ====
// combinational XY routing; row numbers grow southward and dst must lie inside the grid
`timescale 1ns/100ps
`include "fabric_defs.svh"

module route_decode
import mesh_pkg::*;
(
    input  t_tile_id             local_tile_id,
    input  logic                 head_valid,
    input  t_tile_id             dst,
    output logic [NUM_PORTS-1:0] req
);

t_port_dir dir;

// column first, then row
always_comb begin
    if (dst.col > local_tile_id.col) begin
        dir = EAST;
    end else if (dst.col < local_tile_id.col) begin
        dir = WEST;
    end else if (dst.row > local_tile_id.row) begin
        dir = SOUTH;
    end else if (dst.row < local_tile_id.row) begin
        dir = NORTH;
    end else begin
        dir = LOCAL;
    end
end

always_comb begin
    req      = '0;
    req[dir] = head_valid;
end

// next hop has to stay on the grid, else it lands on a tied-off edge
always_comb begin : hop_check
    int next_col;
    int next_row;
    next_col = int'(local_tile_id.col) + int'(dir == EAST) - int'(dir == WEST);
    next_row = int'(local_tile_id.row) + int'(dir == SOUTH) - int'(dir == NORTH);
    if (head_valid) begin
        assert #0 (next_col >= 1 && next_col <= `FABRIC_COLS &&
                   next_row >= 1 && next_row <= `FABRIC_ROWS)
            else $error("route_decode: hop to col %0d row %0d", next_col, next_row);
    end
end

endmodule

// ==== verilog/switch_arbiter.sv ====
// expects one-hot req per input, which keeps each input to a single grant per cycle
`timescale 1ns/100ps

module switch_arbiter
import mesh_pkg::*;
import trans_pkg::*;
(
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] req,
    input  t_tile_trans [NUM_PORTS-1:0]         head_trans,
    output logic [NUM_PORTS-1:0]                pop,
    output logic [NUM_PORTS-1:0]                out_valid,
    output t_tile_trans [NUM_PORTS-1:0]         out_trans,
    input  logic [NUM_PORTS-1:0]                out_ready
);

localparam int IDX_W = $clog2(NUM_PORTS);

logic [IDX_W-1:0]     rr_ptr [NUM_PORTS];
logic [IDX_W-1:0]     winner [NUM_PORTS];
logic [NUM_PORTS-1:0] grant_any;
logic [NUM_PORTS-1:0] load_ok;

// output register is free when empty or draining this cycle
assign load_ok = ~out_valid | out_ready;

// req is indexed [input][output]; search starts at the pointer
always_comb begin : allocate
    int idx;
    pop       = '0;
    grant_any = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
        winner[o] = '0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            idx = (int'(rr_ptr[o]) + k) % NUM_PORTS;
            if (load_ok[o] && !grant_any[o] && req[idx][o]) begin
                grant_any[o] = 1'b1;
                winner[o]    = IDX_W'(idx);
                pop[idx]     = 1'b1;
            end
        end
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        out_valid <= '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            rr_ptr[o] <= '0;
        end
    end else begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (grant_any[o]) begin
                out_valid[o] <= 1'b1;
                // winner drops to lowest priority
                rr_ptr[o] <= (int'(winner[o]) == NUM_PORTS - 1) ? '0 : winner[o] + 1'b1;
            end else if (out_ready[o]) begin
                out_valid[o] <= 1'b0;
            end
        end
    end
end

always_ff @(posedge clk) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
        if (grant_any[o]) begin
            out_trans[o] <= head_trans[winner[o]];
        end
    end
end

for (genvar o = 0; o < NUM_PORTS; o++) begin : g_hold_chk
    // a stalled output keeps valid and payload until the neighbour takes it
    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid[o] && !out_ready[o] |=> out_valid[o] && $stable(out_trans[o]))
        else $error("switch_arbiter: output %0d changed under stall", o);
end

endmodule

// ==== verilog/trans_pkg.sv ====
// packet is src, dst, data from msb down; 32 bits with the default widths
`include "fabric_defs.svh"

package trans_pkg;

    import mesh_pkg::*;

    typedef logic [`DATA_W-1:0] t_data;

    // one flit per packet, no header/tail split
    typedef struct packed {
        t_tile_id src;
        t_tile_id dst;
        t_data    data;
    } t_tile_trans;

endpackage
